// ==== hdl/tenyr_pkg.sv ====
`default_nettype none

package tenyr_pkg;

    localparam int unsigned RAM_WORDS = 1024;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(RAM_WORDS)-1:0] addr_t;

    localparam word_t SEG7_BASE = 32'h0000_0400; // word address of the display register.

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SHL = 4'd5,
        OP_SHR = 4'd6,
        OP_LT  = 4'd7 // all ones when x < y as signed values.
    } opcode_e;

    typedef enum logic [1:0] {
        KIND_REG   = 2'd0, // z gets the result.
        KIND_LOAD  = 2'd1, // z gets the word at the result address.
        KIND_STORE = 2'd2, // the word at the result address gets z.
        KIND_HALT  = 2'd3
    } kind_e;

    // Instruction field layout, lsb positions.
    localparam int KIND_LSB  = 30;
    localparam int Z_LSB     = 26;
    localparam int X_LSB     = 22;
    localparam int Y_LSB     = 18;
    localparam int OP_LSB    = 14;
    localparam int IMM_W     = 14; // signed immediate in bits 13 to 0.
    localparam int REG_IDX_W = 4;

    localparam int STARTUP_CYCLES   = 4;
    localparam int SEG7_SCAN_CYCLES = 16;

    // Active-low patterns, bit 6 is segment g and bit 0 is segment a.
    // Entry 0 sits in the lowest bits, so digit f comes first here.
    localparam logic [15:0][6:0] SEG7_FONT = {
        7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

endpackage

`default_nettype wire

// ==== hdl/dual_port_ram.sv ====
`default_nettype none

module dual_port_ram (
    input  wire logic             clk_core,
    input  wire logic             a_en,
    input  wire logic             a_we,
    input  wire tenyr_pkg::addr_t a_addr,
    input  wire tenyr_pkg::word_t a_wdata,
    input  wire tenyr_pkg::addr_t b_addr,
    output tenyr_pkg::word_t      a_rdata,
    output tenyr_pkg::word_t      b_rdata
);

    import tenyr_pkg::*;

    word_t mem [RAM_WORDS]; // shared by data and instruction ports.

    // Port A is the data port. A write returns the old word on the same cycle.
    always_ff @(posedge clk_core) begin
        if (a_en) begin
            if (a_we) begin
                mem[a_addr] <= a_wdata;
            end
            a_rdata <= mem[a_addr];
        end
    end

    // Port B only fetches instructions, so it reads on every clock.
    always_ff @(posedge clk_core) begin
        b_rdata <= mem[b_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/seg7_device.sv ====
`default_nettype none

module seg7_device (
    input  wire logic             clk_core,
    input  wire logic             rst,
    input  wire logic             wr,
    input  wire tenyr_pkg::word_t wdata,
    output logic [7:0]            seg,
    output logic [3:0]            an
);

    import tenyr_pkg::*;

    localparam int SCAN_W = $clog2(SEG7_SCAN_CYCLES);

    logic [15:0]       value;     // four hex digits on show.
    logic [SCAN_W-1:0] scan_cnt;  // clocks spent on the current digit.
    logic [1:0]        digit;     // index of the lit digit.
    logic [1:0]        digit_nxt;
    logic              scan_wrap;
    logic [3:0]        nibble;

    assign scan_wrap = (scan_cnt == SCAN_W'(SEG7_SCAN_CYCLES - 1));
    assign digit_nxt = scan_wrap ? digit + 2'd1 : digit;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            value <= '0;
        end else if (wr) begin
            value <= wdata[15:0]; // only the low half word is displayed.
        end
    end

    // The enables are registered together with the digit index so they
    // always agree with the nibble that drives the segments.
    always_ff @(posedge clk_core) begin
        if (rst) begin
            scan_cnt <= '0;
            digit    <= '0;
            an       <= 4'hf;
        end else begin
            scan_cnt <= scan_wrap ? '0 : scan_cnt + SCAN_W'(1);
            digit    <= digit_nxt;
            an       <= ~(4'b0001 << digit_nxt);
        end
    end

    assign nibble = value[digit*4 +: 4];
    assign seg    = {1'b1, SEG7_FONT[nibble]}; // decimal point stays dark.

endmodule

`default_nettype wire

// ==== hdl/tenyr_core.sv ====
`default_nettype none

module tenyr_core (
    input  wire logic             clk_core,
    input  wire logic             rst,
    input  wire logic             en,
    input  wire tenyr_pkg::word_t i_data,
    input  wire tenyr_pkg::word_t d_rdata,
    output tenyr_pkg::addr_t      i_addr,
    output tenyr_pkg::word_t      d_addr,
    output tenyr_pkg::word_t      d_wdata,
    output logic                  d_we,
    output logic                  d_en,
    output logic                  halted
);

    import tenyr_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_WB
    } state_e;

    state_e state;
    word_t  pc;              // address of the current instruction.
    word_t  regs [14:1];     // r0 and r15 have no storage here.
    logic [REG_IDX_W-1:0] wb_z; // target of a pending load.

    kind_e                kind;
    opcode_e              op;
    logic [REG_IDX_W-1:0] z_idx;
    logic [REG_IDX_W-1:0] x_idx;
    logic [REG_IDX_W-1:0] y_idx;
    word_t                imm;
    word_t                x_val;
    word_t                y_val;
    word_t                z_val;
    word_t                alu_out;
    word_t                result;

    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    word_t                wr_data;
    logic                 pc_step;

    function automatic word_t reg_read(input logic [REG_IDX_W-1:0] idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (idx == '1) begin
            val = pc + 32'd1; // r15 reads as the next instruction address.
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    // The instruction word is valid on i_data during the execute state.
    assign kind  = kind_e'(i_data[KIND_LSB +: 2]);
    assign op    = opcode_e'(i_data[OP_LSB +: 4]);
    assign z_idx = i_data[Z_LSB +: REG_IDX_W];
    assign x_idx = i_data[X_LSB +: REG_IDX_W];
    assign y_idx = i_data[Y_LSB +: REG_IDX_W];
    assign imm   = {{(32 - IMM_W){i_data[IMM_W-1]}}, i_data[IMM_W-1:0]};

    assign x_val = reg_read(x_idx);
    assign y_val = reg_read(y_idx);
    assign z_val = reg_read(z_idx);

    always_comb begin
        case (op)
            OP_ADD:  alu_out = x_val + y_val;
            OP_SUB:  alu_out = x_val - y_val;
            OP_AND:  alu_out = x_val & y_val;
            OP_OR:   alu_out = x_val | y_val;
            OP_XOR:  alu_out = x_val ^ y_val;
            OP_SHL:  alu_out = x_val << y_val[4:0];
            OP_SHR:  alu_out = x_val >> y_val[4:0];
            OP_LT:   alu_out = ($signed(x_val) < $signed(y_val)) ? '1 : '0;
            default: alu_out = '0;
        endcase
    end

    assign result = alu_out + imm; // address of loads and stores as well.

    assign i_addr  = addr_t'(pc);
    assign d_addr  = result;
    assign d_wdata = z_val;
    assign d_en    = (state == ST_EXEC) && (kind == KIND_LOAD || kind == KIND_STORE);
    assign d_we    = (state == ST_EXEC) && (kind == KIND_STORE);

    // Register file write port and program counter step.
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = z_idx;
        wr_data = result;
        pc_step = 1'b0;
        if (state == ST_EXEC) begin
            if (kind == KIND_REG) begin
                wr_en   = 1'b1;
                pc_step = 1'b1;
            end else if (kind == KIND_STORE) begin
                pc_step = 1'b1;
            end
        end else if (state == ST_WB) begin
            wr_en   = 1'b1;
            wr_idx  = wb_z;
            wr_data = d_rdata;  // RAM data arrives one clock after execute.
            pc_step = 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst || !en) begin
            state  <= ST_FETCH;
            pc     <= '0;
            halted <= 1'b0;
            wb_z   <= '0;
            for (int i = 1; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!halted) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (kind == KIND_LOAD) begin
                        wb_z  <= z_idx;
                        state <= ST_WB;
                    end else begin
                        state <= ST_FETCH;
                    end
                    if (kind == KIND_HALT) begin
                        halted <= 1'b1; // held until reset or en falls.
                    end
                end
                default: state <= ST_FETCH;
            endcase

            if (wr_en && wr_idx == '1) begin
                pc <= wr_data; // writing r15 is a jump.
            end else if (pc_step) begin
                pc <= pc + 32'd1;
            end

            if (wr_en && wr_idx != '0 && wr_idx != '1) begin
                regs[wr_idx] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tenyr_soc.sv ====
`default_nettype none

module tenyr_soc (
    input  wire logic             clk_core,
    input  wire logic             rst,
    input  wire logic             run,
    input  wire logic             prog_valid,
    input  wire tenyr_pkg::addr_t prog_addr,
    input  wire tenyr_pkg::word_t prog_data,
    output logic                  prog_ready,
    output logic                  halt,
    output logic [7:0]            seg,
    output logic [3:0]            an
);

    import tenyr_pkg::*;

    logic [STARTUP_CYCLES-1:0] startup; // fills with ones after reset.
    logic  startup_done;
    logic  dev_rst;
    logic  core_en;
    logic  core_halted;
    logic  prog_fire;

    addr_t i_addr;
    word_t i_data;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata;
    logic  d_we;
    logic  d_en;
    logic  d_in_ram;
    logic  rd_ram_q;    // last data read went to RAM.
    logic  seg7_wr;

    logic  ram_a_en;
    logic  ram_a_we;
    addr_t ram_a_addr;
    word_t ram_a_wdata;
    word_t ram_a_rdata;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            startup <= '0;
        end else begin
            startup <= {startup[STARTUP_CYCLES-2:0], 1'b1};
        end
    end

    assign startup_done = startup[STARTUP_CYCLES-1];
    // The display has registered enables, so it leaves reset one clock early.
    assign dev_rst      = rst || !startup[STARTUP_CYCLES-2];
    assign core_en      = startup_done && run;
    assign halt         = !startup_done || core_halted;

    assign prog_ready = startup_done && !run; // loading only while the core idles.
    assign prog_fire  = prog_valid && prog_ready;

    assign d_in_ram = (d_addr < word_t'(RAM_WORDS));
    assign seg7_wr  = d_en && d_we && (d_addr == SEG7_BASE);

    always_comb begin
        if (!run) begin
            ram_a_en    = prog_fire;
            ram_a_we    = prog_fire;
            ram_a_addr  = prog_addr;
            ram_a_wdata = prog_data;
        end else begin
            ram_a_en    = d_en && d_in_ram;
            ram_a_we    = d_we;
            ram_a_addr  = addr_t'(d_addr);
            ram_a_wdata = d_wdata;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_ram_q <= 1'b0;
        end else begin
            rd_ram_q <= d_in_ram;
        end
    end

    assign d_rdata = rd_ram_q ? ram_a_rdata : '0; // unmapped reads return zero.

    tenyr_core u_core (
        .clk_core (clk_core),
        .rst      (rst),
        .en       (core_en),
        .i_data   (i_data),
        .d_rdata  (d_rdata),
        .i_addr   (i_addr),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_we     (d_we),
        .d_en     (d_en),
        .halted   (core_halted)
    );

    dual_port_ram u_ram (
        .clk_core (clk_core),
        .a_en     (ram_a_en),
        .a_we     (ram_a_we),
        .a_addr   (ram_a_addr),
        .a_wdata  (ram_a_wdata),
        .b_addr   (i_addr),
        .a_rdata  (ram_a_rdata),
        .b_rdata  (i_data)
    );

    seg7_device u_seg7 (
        .clk_core (clk_core),
        .rst      (dev_rst),
        .wr       (seg7_wr),
        .wdata    (d_wdata),
        .seg      (seg),
        .an       (an)
    );

endmodule

`default_nettype wire

// ==== verification/tb_asm.svh ====
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// Fields from msb: kind, z, x, y, op, then a 14-bit signed immediate.
function automatic word_t encode(input kind_e kind, input int z, input int x, input int y,
                                 input opcode_e op, input int imm);
    return {kind, 4'(z), 4'(x), 4'(y), op, 14'(imm)};
endfunction

function automatic word_t reg_insn(input int z, input int x, input opcode_e op, input int y,
                                   input int imm);
    return encode(KIND_REG, z, x, y, op, imm);
endfunction

function automatic word_t load_insn(input int z, input int x, input int imm);
    return encode(KIND_LOAD, z, x, 0, OP_ADD, imm); // address is x + imm.
endfunction

function automatic word_t store_insn(input int z, input int x, input int imm);
    return encode(KIND_STORE, z, x, 0, OP_ADD, imm);
endfunction

function automatic word_t halt_insn();
    return encode(KIND_HALT, 0, 0, 0, OP_ADD, 0);
endfunction

// Each opcode in turn, folded into r10 as acc = 2 * acc ^ result.
task automatic alu_program(input int a, input int b);
    prog = {};
    prog.push_back(reg_insn(1, 0, OP_ADD, 0, a));
    prog.push_back(reg_insn(2, 0, OP_ADD, 0, b));
    for (int i = 0; i < 8; i++) begin
        prog.push_back(reg_insn(3, 1, opcode_e'(i), 2, i)); // immediate i joins each result.
        prog.push_back(reg_insn(10, 10, OP_ADD, 10, 0));
        prog.push_back(reg_insn(10, 10, OP_XOR, 3, 0));
    end
    prog.push_back(store_insn(10, 0, int'(SEG7_BASE)));
    prog.push_back(halt_insn());
endtask

task automatic memory_program(input int a, input int b, input int c);
    prog = {};
    prog.push_back(reg_insn(1, 0, OP_ADD, 0, a));
    prog.push_back(reg_insn(2, 0, OP_ADD, 0, b));
    prog.push_back(reg_insn(3, 0, OP_ADD, 0, c));
    prog.push_back(store_insn(1, 0, 'h200));
    prog.push_back(store_insn(2, 0, 'h201));
    prog.push_back(store_insn(3, 1, 'h100));  // address taken from r1.
    prog.push_back(load_insn(7, 1, 'h100));   // reads the word stored just before.
    prog.push_back(load_insn(5, 0, 'h200));
    prog.push_back(load_insn(6, 0, 'h201));
    prog.push_back(reg_insn(8, 5, OP_ADD, 6, 0)); // r6 is used right after its load.
    prog.push_back(reg_insn(8, 8, OP_SUB, 7, 0));
    prog.push_back(store_insn(8, 0, int'(SEG7_BASE)));
    prog.push_back(halt_insn());
endtask

// The loop body starts at word 4 and the jump sits at word 8.
task automatic sum_loop_program(input int n);
    prog = {};
    prog.push_back(reg_insn(1, 0, OP_ADD, 0, 1));
    prog.push_back(reg_insn(2, 0, OP_ADD, 0, 0));
    prog.push_back(reg_insn(3, 0, OP_ADD, 0, n + 1));
    prog.push_back(reg_insn(6, 0, OP_ADD, 0, 4 - 9)); // r15 reads 9 at the jump.
    prog.push_back(reg_insn(2, 2, OP_ADD, 1, 0));
    prog.push_back(reg_insn(1, 1, OP_ADD, 0, 1));
    prog.push_back(reg_insn(4, 1, OP_LT, 3, 0));
    prog.push_back(reg_insn(5, 4, OP_AND, 6, 0));
    prog.push_back(reg_insn(15, 15, OP_ADD, 5, 0));
    prog.push_back(store_insn(2, 0, int'(SEG7_BASE)));
    prog.push_back(halt_insn());
endtask

task automatic immediate_program(input int a, input int b, input int c);
    prog = {};
    prog.push_back(reg_insn(1, 0, OP_ADD, 0, a));
    prog.push_back(reg_insn(1, 1, OP_ADD, 0, b));
    prog.push_back(reg_insn(1, 1, OP_ADD, 0, c));
    prog.push_back(store_insn(1, 0, int'(SEG7_BASE)));
    prog.push_back(halt_insn());
endtask

`endif

// ==== verification/tb_tenyr_soc.sv ====
`default_nettype none

module tb_tenyr_soc;

    import tenyr_pkg::*;

    // Six programs of up to 200 instructions at three clocks, plus loading,
    // resets and display scans, with a wide margin.
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk_core;
    logic       rst;
    logic       run;
    logic       prog_valid;
    addr_t      prog_addr;
    word_t      prog_data;
    logic       prog_ready;
    logic       halt;
    logic [7:0] seg;
    logic [3:0] an;

    word_t prog[$];   // program image, word 0 first.
    int    checks;
    int    errors;
    int    cycles = 0;

    `include "tb_asm.svh"

    tenyr_soc u_dut (
        .clk_core   (clk_core),
        .rst        (rst),
        .run        (run),
        .prog_valid (prog_valid),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_ready (prog_ready),
        .halt       (halt),
        .seg        (seg),
        .an         (an)
    );

    initial begin
        clk_core = 1'b0;
        forever #10 clk_core = ~clk_core;
    end

    always @(posedge clk_core) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never reached the awaited state",
                     cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_an(input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] an got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    // Reference for the ALU program, built from the opcode definitions.
    function automatic word_t alu_expect(input word_t a, input word_t b);
        word_t res [8];
        word_t acc;
        res[0] = a + b;
        res[1] = a - b;
        res[2] = a & b;
        res[3] = a | b;
        res[4] = a ^ b;
        res[5] = a << b;
        res[6] = a >> b;
        res[7] = ($signed(a) < $signed(b)) ? '1 : '0;
        acc = '0;
        for (int i = 0; i < 8; i++) begin
            acc = (acc + acc) ^ (res[i] + word_t'(i));
        end
        return acc;
    endfunction

    task automatic apply_reset();
        @(posedge clk_core);
        rst        <= 1'b1;
        run        <= 1'b0;
        prog_valid <= 1'b0;
        repeat (2) @(posedge clk_core);
        rst <= 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk_core);
            prog_valid <= 1'b1;
            prog_addr  <= addr_t'(i);
            prog_data  <= prog[i];
            @(negedge clk_core);
            while (!prog_ready) @(negedge clk_core);
        end
        @(posedge clk_core);
        prog_valid <= 1'b0; // the last word is written on this edge.
    endtask

    task automatic start_core();
        @(negedge clk_core);
        while (!prog_ready) @(negedge clk_core);
        @(posedge clk_core);
        run <= 1'b1;
        @(negedge clk_core);
        while (!halt) @(negedge clk_core);
    endtask

    task automatic run_program();
        @(posedge clk_core);
        run <= 1'b0;
        load_program();
        start_core();
    endtask

    task automatic read_display(output logic [15:0] value);
        logic [6:0] pattern;
        logic       found;
        value = '0;
        for (int d = 0; d < 4; d++) begin
            @(negedge clk_core);
            while (an != ~(4'b0001 << d)) @(negedge clk_core);
            pattern = seg[6:0];
            found   = 1'b0;
            compare_bit("seg[7]", seg[7], 1'b1);
            for (int n = 0; n < 16; n++) begin
                if (SEG7_FONT[4'(n)] == pattern) begin
                    value[d*4 +: 4] = 4'(n);
                    found = 1'b1;
                end
            end
            if (!found) begin
                errors++;
                $display("digit %0d of the display shows a pattern that is no hex digit", d);
            end
        end
    endtask

    task automatic startup_sequence();
        repeat (2) @(posedge clk_core);
        rst <= 1'b0;
        for (int i = 0; i < STARTUP_CYCLES; i++) begin
            @(negedge clk_core);
            compare_bit("halt", halt, 1'b1);
            compare_bit("prog_ready", prog_ready, 1'b0);
            compare_an(an, 4'hf);
        end
        @(negedge clk_core);
        compare_bit("prog_ready", prog_ready, 1'b1);
        compare_bit("halt", halt, 1'b0);
        compare_an(an, 4'he); // scanning starts at digit 0.
    endtask

    task automatic alu_ops();
        logic [15:0] shown;
        alu_program(-1893, 5);
        run_program();
        read_display(shown);
        compare_word("display", {16'h0, shown}, alu_expect(-1893, 5) & 32'hffff);
    endtask

    task automatic memory_roundtrip();
        logic [15:0] shown;
        memory_program('h123, 'ha50, -7);
        run_program();
        read_display(shown);
        compare_word("display", {16'h0, shown}, word_t'('h123 + 'ha50 - (-7)) & 32'hffff);
    endtask

    task automatic sum_loop(input int n);
        logic [15:0] shown;
        sum_loop_program(n);
        run_program();
        read_display(shown);
        compare_word("display", {16'h0, shown}, word_t'(n * (n + 1) / 2) & 32'hffff);
        repeat (2 * SEG7_SCAN_CYCLES) begin
            @(negedge clk_core);
            compare_bit("halt", halt, 1'b1);
        end
    endtask

    task automatic load_backpressure();
        logic [15:0] shown;
        word_t       expect_val;
        expect_val = word_t'('h123 + 'ha50 - (-7)) & 32'hffff;
        memory_program('h123, 'ha50, -7);
        run_program();
        read_display(shown);
        compare_word("display", {16'h0, shown}, expect_val);
        @(posedge clk_core);
        prog_valid <= 1'b1;
        prog_addr  <= '0;
        prog_data  <= halt_insn(); // would stop the program at its first word.
        repeat (2 * SEG7_SCAN_CYCLES) begin
            @(negedge clk_core);
            compare_bit("prog_ready", prog_ready, 1'b0);
        end
        @(posedge clk_core);
        prog_valid <= 1'b0;
        apply_reset();       // also clears the display.
        start_core();
        read_display(shown);
        compare_word("display", {16'h0, shown}, expect_val);
    endtask

    task automatic random_immediates();
        logic [15:0] shown;
        logic [13:0] raw;
        int          imm [3];
        int          sum;
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            raw    = 14'($urandom);
            imm[i] = int'($signed(raw));
            sum    += imm[i];
        end
        immediate_program(imm[0], imm[1], imm[2]);
        run_program();
        read_display(shown);
        compare_word("display", {16'h0, shown}, word_t'(sum) & 32'hffff);
    endtask

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        prog_valid = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        checks     = 0;
        errors     = 0;
        void'($urandom(32'hfcfe));
        startup_sequence();
        alu_ops();
        memory_roundtrip();
        sum_loop(30);
        load_backpressure();
        random_immediates();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
hdl/tenyr_pkg.sv
hdl/dual_port_ram.sv
hdl/seg7_device.sv
hdl/tenyr_core.sv
hdl/tenyr_soc.sv
verification/tb_tenyr_soc.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module tb_tenyr_soc -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/Vtb_tenyr_soc)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
